// ==== Makefile ====
TOP = tb_bwt_ext
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f bwt_ext.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== bwt_ext.f ====
logic/bwt_ext_pkg.sv
logic/ext_step_if.sv
logic/ext_ctrl_stage.sv
logic/ext_decide_stage.sv
logic/ext_update_stage.sv
logic/ext_request_stage.sv
logic/bwt_ext_top.sv
verif/tb_clk_gen.sv
verif/tb_bwt_ext.sv

// ==== logic/bwt_ext_pkg.sv ====
package bwt_ext_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int BWT_IDX_W  = 64;                        // one bwt index / interval field
	localparam int NUM_BASES  = 4;                         // a c g t
	localparam int READ_NUM_W = 10;                        // read slots in flight

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic [BWT_IDX_W-1:0]           bwt_idx_t;     // k, l, x0..x2, info
	typedef logic [NUM_BASES*BWT_IDX_W-1:0] cand_t;        // lane c holds base c
	typedef logic [6:0]                     pos_t;         // read position, ptr, min_intv
	typedef logic [READ_NUM_W-1:0]          read_num_t;
	typedef logic [7:0]                     query_t;       // base in [1:0]
	typedef logic [31:0]                    dram_addr_t;   // occ block word address
	typedef logic [4*BWT_IDX_W-1:0]         curr_word_t;   // {info, x2, x1, x0}

	// ------------------------------
	// per-read status
	// ------------------------------
	// codes above BCK_INI belong to later engines and
	// travel through this datapath untouched
	typedef enum logic [5:0] {
		BUBBLE  = 6'd0,                                     // empty slot
		F_INIT  = 6'd1,                                     // first forward step
		F_RUN   = 6'd2,                                     // forward extension
		F_BREAK = 6'd3,                                     // forward done, return pending
		BCK_INI = 6'd4                                      // hand over to backward search
	} ext_status_e;

endpackage

// ==== logic/bwt_ext_top.sv ====
`timescale 1ns/10ps

module bwt_ext_top #(
	parameter int READ_LEN = 101
) (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,                  // freezes the whole pipe
	input  bwt_ext_pkg::bwt_idx_t    primary_i,
	input  bwt_ext_pkg::ext_status_e status_i,
	input  bwt_ext_pkg::query_t      query_i,
	input  bwt_ext_pkg::pos_t        ptr_curr_i,
	input  bwt_ext_pkg::read_num_t   read_num_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x0_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x1_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x2_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_info_i,
	input  bwt_ext_pkg::pos_t        forward_i_i,
	input  bwt_ext_pkg::pos_t        min_intv_i,
	input  bwt_ext_pkg::pos_t        backward_x_i,
	input  bwt_ext_pkg::cand_t       cand_x0_i,
	input  bwt_ext_pkg::cand_t       cand_x1_i,
	input  bwt_ext_pkg::cand_t       cand_x2_i,
	output logic                     curr_we_o,
	output bwt_ext_pkg::pos_t        curr_addr_o,
	output bwt_ext_pkg::curr_word_t  curr_data_o,
	output bwt_ext_pkg::read_num_t   curr_read_num_o,
	output logic                     ret_valid_o,
	output bwt_ext_pkg::pos_t        ret_o,
	output bwt_ext_pkg::read_num_t   ret_read_num_o,
	output logic                     dram_valid_o,
	output bwt_ext_pkg::dram_addr_t  addr_k_o,
	output bwt_ext_pkg::dram_addr_t  addr_l_o,
	output bwt_ext_pkg::ext_status_e qry_status_o,
	output bwt_ext_pkg::read_num_t   qry_read_num_o,
	output bwt_ext_pkg::pos_t        qry_position_o,
	output bwt_ext_pkg::ext_status_e status_o,
	output bwt_ext_pkg::pos_t        ptr_curr_o,
	output bwt_ext_pkg::read_num_t   read_num_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x0_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x1_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x2_o,
	output bwt_ext_pkg::bwt_idx_t    ik_info_o,
	output bwt_ext_pkg::pos_t        forward_i_o,
	output bwt_ext_pkg::pos_t        min_intv_o,
	output bwt_ext_pkg::pos_t        backward_x_o
);
	import bwt_ext_pkg::*;

	// ------------------------------
	// stage links
	// ------------------------------
	ext_step_if s_ctrl ();                                  // ctrl -> decide, with candidates
	ext_step_if s_dec ();                                   // decide -> update
	ext_step_if s_upd ();                                   // update -> request

	bwt_idx_t tgt_x0;                                       // selected ok[c]
	bwt_idx_t tgt_x1;
	bwt_idx_t tgt_x2;
	logic     upd_ik;
	logic     add_i;
	bwt_idx_t k_tmp;
	bwt_idx_t l_tmp;
	bwt_idx_t k_tmp_m1;
	bwt_idx_t l_tmp_m1;

	ext_ctrl_stage #(.READ_LEN(READ_LEN)) u_ctrl (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.status_i(status_i), .query_i(query_i), .ptr_curr_i(ptr_curr_i),
		.read_num_i(read_num_i), .ik_x0_i(ik_x0_i), .ik_x1_i(ik_x1_i),
		.ik_x2_i(ik_x2_i), .ik_info_i(ik_info_i), .forward_i_i(forward_i_i),
		.min_intv_i(min_intv_i), .backward_x_i(backward_x_i),
		.cand_x0_i(cand_x0_i), .cand_x1_i(cand_x1_i), .cand_x2_i(cand_x2_i),
		.out_o(s_ctrl.src)
	);

	ext_decide_stage #(.READ_LEN(READ_LEN)) u_decide (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.in_i(s_ctrl.dst), .out_o(s_dec.src),
		.tgt_x0_o(tgt_x0), .tgt_x1_o(tgt_x1), .tgt_x2_o(tgt_x2),
		.upd_ik_o(upd_ik), .add_i_o(add_i),
		.curr_we_o(curr_we_o), .curr_addr_o(curr_addr_o), .curr_data_o(curr_data_o),
		.curr_read_num_o(curr_read_num_o), .ret_valid_o(ret_valid_o), .ret_o(ret_o),
		.ret_read_num_o(ret_read_num_o)
	);

	ext_update_stage u_update (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.in_i(s_dec.dst), .tgt_x0_i(tgt_x0), .tgt_x1_i(tgt_x1), .tgt_x2_i(tgt_x2),
		.upd_ik_i(upd_ik), .add_i_i(add_i), .out_o(s_upd.src),
		.k_tmp_o(k_tmp), .l_tmp_o(l_tmp), .k_tmp_m1_o(k_tmp_m1), .l_tmp_m1_o(l_tmp_m1)
	);

	ext_request_stage u_request (
		.Clk_32UI(Clk_32UI), .reset_BWT_extend(reset_BWT_extend), .stall_i(stall_i),
		.primary_i(primary_i), .in_i(s_upd.dst),
		.k_tmp_i(k_tmp), .l_tmp_i(l_tmp), .k_tmp_m1_i(k_tmp_m1), .l_tmp_m1_i(l_tmp_m1),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.qry_status_o(qry_status_o), .qry_read_num_o(qry_read_num_o),
		.qry_position_o(qry_position_o), .status_o(status_o), .ptr_curr_o(ptr_curr_o),
		.read_num_o(read_num_o), .ik_x0_o(ik_x0_o), .ik_x1_o(ik_x1_o), .ik_x2_o(ik_x2_o),
		.ik_info_o(ik_info_o), .forward_i_o(forward_i_o), .min_intv_o(min_intv_o),
		.backward_x_o(backward_x_o)
	);

endmodule

// ==== logic/ext_ctrl_stage.sv ====
`timescale 1ns/10ps

module ext_ctrl_stage #(
	parameter int READ_LEN = 101
) (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_ext_pkg::ext_status_e status_i,
	input  bwt_ext_pkg::query_t      query_i,
	input  bwt_ext_pkg::pos_t        ptr_curr_i,
	input  bwt_ext_pkg::read_num_t   read_num_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x0_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x1_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_x2_i,
	input  bwt_ext_pkg::bwt_idx_t    ik_info_i,
	input  bwt_ext_pkg::pos_t        forward_i_i,
	input  bwt_ext_pkg::pos_t        min_intv_i,
	input  bwt_ext_pkg::pos_t        backward_x_i,
	input  bwt_ext_pkg::cand_t       cand_x0_i,
	input  bwt_ext_pkg::cand_t       cand_x1_i,
	input  bwt_ext_pkg::cand_t       cand_x2_i,
	ext_step_if.src                  out_o
);
	import bwt_ext_pkg::*;

	localparam pos_t LEN_P = pos_t'(READ_LEN);             // read length in position width

	logic read_done;                                        // forward walk reached end of read

	assign read_done = (status_i == F_RUN) && (forward_i_i >= LEN_P);

	// ------------------------------
	// entry register
	// ------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out_o.status <= BUBBLE;
		end else if (!stall_i) begin
			out_o.status     <= read_done ? F_BREAK : status_i; // finished reads go to return
			out_o.query      <= query_i;
			out_o.ptr_curr   <= ptr_curr_i;
			out_o.read_num   <= read_num_i;
			out_o.ik_x0      <= ik_x0_i;
			out_o.ik_x1      <= ik_x1_i;
			out_o.ik_x2      <= ik_x2_i;
			out_o.ik_info    <= ik_info_i;
			out_o.forward_i  <= forward_i_i;
			out_o.min_intv   <= min_intv_i;
			out_o.backward_x <= backward_x_i;
			out_o.cand_x0    <= cand_x0_i;                  // candidates stay aligned with record
			out_o.cand_x1    <= cand_x1_i;
			out_o.cand_x2    <= cand_x2_i;
		end
	end

endmodule

// ==== logic/ext_decide_stage.sv ====
`timescale 1ns/10ps

module ext_decide_stage #(
	parameter int READ_LEN = 101
) (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	ext_step_if.dst                  in_i,
	ext_step_if.src                  out_o,
	output bwt_ext_pkg::bwt_idx_t    tgt_x0_o,
	output bwt_ext_pkg::bwt_idx_t    tgt_x1_o,
	output bwt_ext_pkg::bwt_idx_t    tgt_x2_o,
	output logic                     upd_ik_o,
	output logic                     add_i_o,
	output logic                     curr_we_o,
	output bwt_ext_pkg::pos_t        curr_addr_o,
	output bwt_ext_pkg::curr_word_t  curr_data_o,
	output bwt_ext_pkg::read_num_t   curr_read_num_o,
	output logic                     ret_valid_o,
	output bwt_ext_pkg::pos_t        ret_o,
	output bwt_ext_pkg::read_num_t   ret_read_num_o
);
	import bwt_ext_pkg::*;

	localparam pos_t LEN_P = pos_t'(READ_LEN);

	logic [1:0] lane;                                       // candidate lane for this step
	logic [7:0] lane_lsb;                                   // bit offset of that lane
	bwt_idx_t   sel_x0;
	bwt_idx_t   sel_x1;
	bwt_idx_t   sel_x2;
	pos_t       ptr_inc;
	logic       ik_changed;
	logic       below_min;

	assign lane       = 2'd3 - in_i.query[1:0];            // complement of query base
	assign lane_lsb   = {lane, 6'd0};
	assign sel_x0     = in_i.cand_x0[lane_lsb +: 64];
	assign sel_x1     = in_i.cand_x1[lane_lsb +: 64];
	assign sel_x2     = in_i.cand_x2[lane_lsb +: 64];
	assign ptr_inc    = in_i.ptr_curr + 7'd1;
	assign ik_changed = (sel_x2 != in_i.ik_x2);            // interval shrank, keep old one
	assign below_min  = (sel_x2 < bwt_idx_t'(in_i.min_intv));

	// no candidates beyond this point
	assign out_o.cand_x0 = '0;
	assign out_o.cand_x1 = '0;
	assign out_o.cand_x2 = '0;

	// ------------------------------
	// decision register
	// ------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out_o.status <= BUBBLE;
			upd_ik_o     <= 1'b0;
			add_i_o      <= 1'b0;
			curr_we_o    <= 1'b0;
			ret_valid_o  <= 1'b0;
		end else if (!stall_i) begin
			out_o.status   <= in_i.status;                  // default pass through
			out_o.ptr_curr <= in_i.ptr_curr;
			upd_ik_o       <= 1'b0;
			add_i_o        <= 1'b0;
			curr_we_o      <= 1'b0;
			ret_valid_o    <= 1'b0;
			case (in_i.status)
				F_RUN: begin
					upd_ik_o <= 1'b1;
					add_i_o  <= 1'b1;
					if (ik_changed) begin
						curr_we_o      <= 1'b1;             // push previous ik
						out_o.ptr_curr <= ptr_inc;
						if (below_min) begin
							out_o.status <= F_BREAK;        // too few hits, stop here
							upd_ik_o     <= 1'b0;
							add_i_o      <= 1'b0;
						end
					end
				end
				F_BREAK: begin
					ret_valid_o  <= 1'b1;                   // report break position
					out_o.status <= BCK_INI;
					if (in_i.forward_i == LEN_P) begin
						curr_we_o      <= 1'b1;             // full read match, push last ik
						out_o.ptr_curr <= ptr_inc;
					end
				end
				default: ;
			endcase
			curr_data_o      <= {in_i.ik_info, in_i.ik_x2, in_i.ik_x1, in_i.ik_x0};
			curr_addr_o      <= in_i.ptr_curr;
			curr_read_num_o  <= in_i.read_num;
			ret_o            <= in_i.ik_info[6:0];
			ret_read_num_o   <= in_i.read_num;
			tgt_x0_o         <= sel_x0;
			tgt_x1_o         <= sel_x1;
			tgt_x2_o         <= sel_x2;
			out_o.query      <= in_i.query;
			out_o.read_num   <= in_i.read_num;
			out_o.ik_x0      <= in_i.ik_x0;
			out_o.ik_x1      <= in_i.ik_x1;
			out_o.ik_x2      <= in_i.ik_x2;
			out_o.ik_info    <= in_i.ik_info;
			out_o.forward_i  <= in_i.forward_i;
			out_o.min_intv   <= in_i.min_intv;
			out_o.backward_x <= in_i.backward_x;
		end
	end

endmodule

// ==== logic/ext_request_stage.sv ====
`timescale 1ns/10ps

module ext_request_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	input  bwt_ext_pkg::bwt_idx_t    primary_i,
	ext_step_if.dst                  in_i,
	input  bwt_ext_pkg::bwt_idx_t    k_tmp_i,
	input  bwt_ext_pkg::bwt_idx_t    l_tmp_i,
	input  bwt_ext_pkg::bwt_idx_t    k_tmp_m1_i,
	input  bwt_ext_pkg::bwt_idx_t    l_tmp_m1_i,
	output logic                     dram_valid_o,
	output bwt_ext_pkg::dram_addr_t  addr_k_o,
	output bwt_ext_pkg::dram_addr_t  addr_l_o,
	output bwt_ext_pkg::ext_status_e qry_status_o,
	output bwt_ext_pkg::read_num_t   qry_read_num_o,
	output bwt_ext_pkg::pos_t        qry_position_o,
	output bwt_ext_pkg::ext_status_e status_o,
	output bwt_ext_pkg::pos_t        ptr_curr_o,
	output bwt_ext_pkg::read_num_t   read_num_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x0_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x1_o,
	output bwt_ext_pkg::bwt_idx_t    ik_x2_o,
	output bwt_ext_pkg::bwt_idx_t    ik_info_o,
	output bwt_ext_pkg::pos_t        forward_i_o,
	output bwt_ext_pkg::pos_t        min_intv_o,
	output bwt_ext_pkg::pos_t        backward_x_o
);
	import bwt_ext_pkg::*;

	bwt_idx_t k_sel;                                        // primary row skipped
	bwt_idx_t l_sel;
	logic     req_on;                                       // step needs occ blocks

	assign k_sel  = (k_tmp_i >= primary_i) ? k_tmp_m1_i : k_tmp_i;
	assign l_sel  = (l_tmp_i >= primary_i) ? l_tmp_m1_i : l_tmp_i;
	assign req_on = (in_i.status == F_INIT) || (in_i.status == F_RUN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			status_o     <= BUBBLE;
			qry_status_o <= BUBBLE;
			dram_valid_o <= 1'b0;
		end else if (!stall_i) begin
			dram_valid_o   <= req_on;                       // no access after a break
			addr_k_o       <= req_on ? {k_sel[34:7], 4'b0} : '0; // 128-row occ block
			addr_l_o       <= req_on ? {l_sel[34:7], 4'b0} : '0;
			status_o       <= (in_i.status == F_INIT) ? F_RUN : in_i.status;
			qry_status_o   <= in_i.status;                  // next query fetch
			qry_read_num_o <= in_i.read_num;
			qry_position_o <= in_i.forward_i;
			ptr_curr_o     <= in_i.ptr_curr;
			read_num_o     <= in_i.read_num;
			ik_x0_o        <= in_i.ik_x0;
			ik_x1_o        <= in_i.ik_x1;
			ik_x2_o        <= in_i.ik_x2;
			ik_info_o      <= in_i.ik_info;
			forward_i_o    <= in_i.forward_i;
			min_intv_o     <= in_i.min_intv;
			backward_x_o   <= in_i.backward_x;
		end
	end

endmodule

// ==== logic/ext_step_if.sv ====
`timescale 1ns/10ps

interface ext_step_if;
	import bwt_ext_pkg::*;

	ext_status_e status;                                    // slot status, BUBBLE when empty
	query_t      query;                                     // current query symbol
	pos_t        ptr_curr;                                  // next free curr queue entry
	read_num_t   read_num;
	bwt_idx_t    ik_x0;                                     // current bi-interval
	bwt_idx_t    ik_x1;
	bwt_idx_t    ik_x2;                                     // interval size
	bwt_idx_t    ik_info;                                   // position tag
	pos_t        forward_i;                                 // forward position in read
	pos_t        min_intv;
	pos_t        backward_x;
	cand_t       cand_x0;                                   // extension candidates, one lane per base
	cand_t       cand_x1;
	cand_t       cand_x2;

	// ------------------------------
	modport src (
		output status, query, ptr_curr, read_num,
		output ik_x0, ik_x1, ik_x2, ik_info,
		output forward_i, min_intv, backward_x,
		output cand_x0, cand_x1, cand_x2
	);

	modport dst (
		input status, query, ptr_curr, read_num,
		input ik_x0, ik_x1, ik_x2, ik_info,
		input forward_i, min_intv, backward_x,
		input cand_x0, cand_x1, cand_x2
	);

endinterface

// ==== logic/ext_update_stage.sv ====
`timescale 1ns/10ps

module ext_update_stage (
	input  logic                     Clk_32UI,
	input  logic                     reset_BWT_extend,
	input  logic                     stall_i,
	ext_step_if.dst                  in_i,
	input  bwt_ext_pkg::bwt_idx_t    tgt_x0_i,
	input  bwt_ext_pkg::bwt_idx_t    tgt_x1_i,
	input  bwt_ext_pkg::bwt_idx_t    tgt_x2_i,
	input  logic                     upd_ik_i,
	input  logic                     add_i_i,
	ext_step_if.src                  out_o,
	output bwt_ext_pkg::bwt_idx_t    k_tmp_o,
	output bwt_ext_pkg::bwt_idx_t    l_tmp_o,
	output bwt_ext_pkg::bwt_idx_t    k_tmp_m1_o,
	output bwt_ext_pkg::bwt_idx_t    l_tmp_m1_o
);
	import bwt_ext_pkg::*;

	logic     take_tgt;                                     // ik = ok[c]
	logic     step_i;                                       // i++
	bwt_idx_t nxt_x0;
	bwt_idx_t nxt_x1;
	bwt_idx_t nxt_x2;
	bwt_idx_t nxt_info;
	bwt_idx_t k_base;                                       // k = x1 - 1
	bwt_idx_t l_base;                                       // l = k + x2

	assign take_tgt = (in_i.status == F_RUN) && upd_ik_i;
	assign step_i   = (in_i.status == F_RUN) && add_i_i;
	assign nxt_x0   = take_tgt ? tgt_x0_i : in_i.ik_x0;
	assign nxt_x1   = take_tgt ? tgt_x1_i : in_i.ik_x1;
	assign nxt_x2   = take_tgt ? tgt_x2_i : in_i.ik_x2;
	assign nxt_info = take_tgt ? ({57'd0, in_i.forward_i} + 64'd1) : in_i.ik_info; // info = i + 1
	assign k_base   = nxt_x1 - 64'd1;
	assign l_base   = k_base + nxt_x2;

	assign out_o.cand_x0 = '0;
	assign out_o.cand_x1 = '0;
	assign out_o.cand_x2 = '0;

	// ------------------------------
	// ik update, k/l precompute
	// ------------------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			out_o.status <= BUBBLE;
		end else if (!stall_i) begin
			out_o.status     <= in_i.status;
			out_o.ik_x0      <= nxt_x0;
			out_o.ik_x1      <= nxt_x1;
			out_o.ik_x2      <= nxt_x2;
			out_o.ik_info    <= nxt_info;
			out_o.forward_i  <= step_i ? (in_i.forward_i + 7'd1) : in_i.forward_i;
			k_tmp_o          <= k_base;
			l_tmp_o          <= l_base;
			k_tmp_m1_o       <= k_base - 64'd1;             // both primary variants ready early
			l_tmp_m1_o       <= l_base - 64'd1;
			out_o.query      <= in_i.query;
			out_o.ptr_curr   <= in_i.ptr_curr;
			out_o.read_num   <= in_i.read_num;
			out_o.min_intv   <= in_i.min_intv;
			out_o.backward_x <= in_i.backward_x;
		end
	end

endmodule

// ==== verif/tb_bwt_ext.sv ====
`timescale 1ns/10ps

module tb_bwt_ext;
	import bwt_ext_pkg::*;

	localparam int READ_LEN    = 101;
	localparam int MAX_ITEMS   = 128;
	localparam int N_RAND      = 60;                        // records in the stream test
	localparam int TIMEOUT_CYC = 2000;                      // tests and reset need about 130 cycles

	typedef logic [255:0] wide_t;                           // widest compared value

	// ------------------------------
	// DUT ports
	// ------------------------------
	logic        Clk_32UI;
	logic        reset_BWT_extend;
	logic        stall_i;
	bwt_idx_t    primary_i;
	ext_status_e status_i;
	query_t      query_i;
	pos_t        ptr_curr_i;
	read_num_t   read_num_i;
	bwt_idx_t    ik_x0_i;
	bwt_idx_t    ik_x1_i;
	bwt_idx_t    ik_x2_i;
	bwt_idx_t    ik_info_i;
	pos_t        forward_i_i;
	pos_t        min_intv_i;
	pos_t        backward_x_i;
	cand_t       cand_x0_i;
	cand_t       cand_x1_i;
	cand_t       cand_x2_i;
	logic        curr_we_o;
	pos_t        curr_addr_o;
	curr_word_t  curr_data_o;
	read_num_t   curr_read_num_o;
	logic        ret_valid_o;
	pos_t        ret_o;
	read_num_t   ret_read_num_o;
	logic        dram_valid_o;
	dram_addr_t  addr_k_o;
	dram_addr_t  addr_l_o;
	ext_status_e qry_status_o;
	read_num_t   qry_read_num_o;
	pos_t        qry_position_o;
	ext_status_e status_o;
	pos_t        ptr_curr_o;
	read_num_t   read_num_o;
	bwt_idx_t    ik_x0_o;
	bwt_idx_t    ik_x1_o;
	bwt_idx_t    ik_x2_o;
	bwt_idx_t    ik_info_o;
	pos_t        forward_i_o;
	pos_t        min_intv_o;
	pos_t        backward_x_o;

	// ------------------------------
	// stimulus records and predictions
	// ------------------------------
	ext_status_e it_status [MAX_ITEMS];
	query_t      it_query  [MAX_ITEMS];
	pos_t        it_ptr    [MAX_ITEMS];
	pos_t        it_fwd    [MAX_ITEMS];
	pos_t        it_min    [MAX_ITEMS];
	pos_t        it_bx     [MAX_ITEMS];
	read_num_t   it_rn     [MAX_ITEMS];
	bwt_idx_t    it_x0     [MAX_ITEMS];
	bwt_idx_t    it_x1     [MAX_ITEMS];
	bwt_idx_t    it_x2     [MAX_ITEMS];
	bwt_idx_t    it_info   [MAX_ITEMS];
	cand_t       it_c0     [MAX_ITEMS];
	cand_t       it_c1     [MAX_ITEMS];
	cand_t       it_c2     [MAX_ITEMS];
	logic        ex_we     [MAX_ITEMS];                     // curr queue write expected
	logic        ex_ret_v  [MAX_ITEMS];
	logic        ex_dram   [MAX_ITEMS];
	ext_status_e ex_status [MAX_ITEMS];
	ext_status_e ex_qst    [MAX_ITEMS];                     // status seen by the request stage
	pos_t        ex_ptr    [MAX_ITEMS];
	pos_t        ex_fwd    [MAX_ITEMS];
	bwt_idx_t    ex_x0     [MAX_ITEMS];
	bwt_idx_t    ex_x1     [MAX_ITEMS];
	bwt_idx_t    ex_x2     [MAX_ITEMS];
	bwt_idx_t    ex_info   [MAX_ITEMS];
	dram_addr_t  ex_ak     [MAX_ITEMS];
	dram_addr_t  ex_al     [MAX_ITEMS];

	int n_items  = 0;
	int n_checks = 0;
	int cyc_cnt  = 0;
	int slot [4] = '{-1, -1, -1, -1};                       // item held after each stage (-1 empty)

	tb_clk_gen u_clk (.clk_o(Clk_32UI), .rst_n_o(reset_BWT_extend));

	bwt_ext_top #(.READ_LEN(READ_LEN)) UUT (.*);

	always @(posedge Clk_32UI) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYC) begin
			$display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic bwt_idx_t rand64();
		return {$urandom, $urandom};
	endfunction

	task automatic check_val(input string name, input wide_t act, input wide_t exp);
		n_checks++;
		if (act !== exp) begin
			$display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, act);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic predict(input int idx);
		ext_status_e st;
		cand_t       tmp;
		bwt_idx_t    t0;
		bwt_idx_t    t1;
		bwt_idx_t    t2;
		bwt_idx_t    kt;
		bwt_idx_t    lt;
		bwt_idx_t    kk;
		bwt_idx_t    ll;
		pos_t        ptr;
		logic        take;
		int          c;
		st   = it_status[idx];
		ptr  = it_ptr[idx];
		take = 1'b0;
		c    = 3 - int'(it_query[idx][1:0]);                // complement base picks the lane
		tmp  = it_c0[idx];
		t0   = tmp[c*64 +: 64];
		tmp  = it_c1[idx];
		t1   = tmp[c*64 +: 64];
		tmp  = it_c2[idx];
		t2   = tmp[c*64 +: 64];
		ex_we[idx]    = 1'b0;
		ex_ret_v[idx] = 1'b0;
		if (st == F_RUN && int'(it_fwd[idx]) >= READ_LEN)
			st = F_BREAK;                                   // end of read reached
		if (st == F_RUN) begin
			take = 1'b1;
			if (t2 != it_x2[idx]) begin
				ex_we[idx] = 1'b1;                          // old ik goes to the queue
				ptr        = ptr + 7'd1;
				if (t2 < bwt_idx_t'(it_min[idx])) begin
					st   = F_BREAK;
					take = 1'b0;
				end
			end
		end else if (st == F_BREAK) begin
			ex_ret_v[idx] = 1'b1;
			if (int'(it_fwd[idx]) == READ_LEN) begin
				ex_we[idx] = 1'b1;                          // whole read matched
				ptr        = ptr + 7'd1;
			end
			st = BCK_INI;
		end
		ex_x0[idx]   = take ? t0 : it_x0[idx];
		ex_x1[idx]   = take ? t1 : it_x1[idx];
		ex_x2[idx]   = take ? t2 : it_x2[idx];
		ex_info[idx] = take ? bwt_idx_t'(it_fwd[idx]) + 64'd1 : it_info[idx];
		ex_fwd[idx]  = take ? it_fwd[idx] + 7'd1 : it_fwd[idx];
		kt = ex_x1[idx] - 64'd1;
		lt = kt + ex_x2[idx];
		kk = (kt >= primary_i) ? kt - 64'd1 : kt;           // skip the primary row
		ll = (lt >= primary_i) ? lt - 64'd1 : lt;
		ex_dram[idx]   = (st == F_INIT) || (st == F_RUN);
		ex_ak[idx]     = ex_dram[idx] ? {kk[34:7], 4'b0000} : 32'd0;
		ex_al[idx]     = ex_dram[idx] ? {ll[34:7], 4'b0000} : 32'd0;
		ex_qst[idx]    = st;
		ex_status[idx] = (st == F_INIT) ? F_RUN : st;
		ex_ptr[idx]    = ptr;
	endtask

	// record with random fill and a given target lane x2
	// primary_i is set before the call
	task automatic add_item(input ext_status_e st, input query_t q, input pos_t ptr,
			input pos_t fwd, input pos_t min, input bwt_idx_t x2, input bwt_idx_t t2);
		cand_t tmp;
		int    i;
		i = n_items;
		it_status[i] = st;
		it_query[i]  = q;
		it_ptr[i]    = ptr;
		it_fwd[i]    = fwd;
		it_min[i]    = min;
		it_bx[i]     = pos_t'($urandom_range(0, 127));
		it_rn[i]     = read_num_t'(i + 300);
		it_x0[i]     = rand64();
		it_x1[i]     = rand64();
		it_x2[i]     = x2;
		it_info[i]   = rand64();
		it_c0[i]     = {rand64(), rand64(), rand64(), rand64()};
		it_c1[i]     = {rand64(), rand64(), rand64(), rand64()};
		tmp          = {rand64(), rand64(), rand64(), rand64()};
		tmp[(3 - int'(q[1:0]))*64 +: 64] = t2;
		it_c2[i]     = tmp;
		n_items++;
		predict(i);
	endtask

	task automatic drive(input int item);
		if (item < 0) begin
			status_i = BUBBLE;                              // empty slot
		end else begin
			status_i     = it_status[item];
			query_i      = it_query[item];
			ptr_curr_i   = it_ptr[item];
			read_num_i   = it_rn[item];
			ik_x0_i      = it_x0[item];
			ik_x1_i      = it_x1[item];
			ik_x2_i      = it_x2[item];
			ik_info_i    = it_info[item];
			forward_i_i  = it_fwd[item];
			min_intv_i   = it_min[item];
			backward_x_i = it_bx[item];
			cand_x0_i    = it_c0[item];
			cand_x1_i    = it_c1[item];
			cand_x2_i    = it_c2[item];
		end
	endtask

	task automatic compare_outputs();
		int d;
		int r;
		d = slot[1];                                        // decide register contents
		r = slot[3];                                        // request register contents
		if (d < 0) begin
			check_val("curr_we_o", wide_t'(curr_we_o), wide_t'(1'b0));
			check_val("ret_valid_o", wide_t'(ret_valid_o), wide_t'(1'b0));
		end else begin
			check_val("curr_we_o", wide_t'(curr_we_o), wide_t'(ex_we[d]));
			check_val("curr_addr_o", wide_t'(curr_addr_o), wide_t'(it_ptr[d]));
			check_val("curr_data_o", wide_t'(curr_data_o),
				{it_info[d], it_x2[d], it_x1[d], it_x0[d]});
			check_val("curr_read_num_o", wide_t'(curr_read_num_o), wide_t'(it_rn[d]));
			check_val("ret_valid_o", wide_t'(ret_valid_o), wide_t'(ex_ret_v[d]));
			if (ex_ret_v[d]) begin
				check_val("ret_o", wide_t'(ret_o), wide_t'(it_info[d][6:0]));
				check_val("ret_read_num_o", wide_t'(ret_read_num_o), wide_t'(it_rn[d]));
			end
		end
		if (r < 0) begin
			check_val("dram_valid_o", wide_t'(dram_valid_o), wide_t'(1'b0));
			check_val("status_o", wide_t'(status_o), wide_t'(BUBBLE));
		end else begin
			check_val("status_o", wide_t'(status_o), wide_t'(ex_status[r]));
			check_val("ptr_curr_o", wide_t'(ptr_curr_o), wide_t'(ex_ptr[r]));
			check_val("read_num_o", wide_t'(read_num_o), wide_t'(it_rn[r]));
			check_val("ik_x0_o", wide_t'(ik_x0_o), wide_t'(ex_x0[r]));
			check_val("ik_x1_o", wide_t'(ik_x1_o), wide_t'(ex_x1[r]));
			check_val("ik_x2_o", wide_t'(ik_x2_o), wide_t'(ex_x2[r]));
			check_val("ik_info_o", wide_t'(ik_info_o), wide_t'(ex_info[r]));
			check_val("forward_i_o", wide_t'(forward_i_o), wide_t'(ex_fwd[r]));
			check_val("min_intv_o", wide_t'(min_intv_o), wide_t'(it_min[r]));
			check_val("backward_x_o", wide_t'(backward_x_o), wide_t'(it_bx[r]));
			check_val("dram_valid_o", wide_t'(dram_valid_o), wide_t'(ex_dram[r]));
			check_val("addr_k_o", wide_t'(addr_k_o), wide_t'(ex_ak[r]));
			check_val("addr_l_o", wide_t'(addr_l_o), wide_t'(ex_al[r]));
			check_val("qry_status_o", wide_t'(qry_status_o), wide_t'(ex_qst[r]));
			check_val("qry_read_num_o", wide_t'(qry_read_num_o), wide_t'(it_rn[r]));
			check_val("qry_position_o", wide_t'(qry_position_o), wide_t'(ex_fwd[r]));
		end
	endtask

	// one clock from falling edge to falling edge
	task automatic step(input int item, input logic hold);
		stall_i = hold;
		drive(item);
		@(posedge Clk_32UI);
		if (!hold) begin                                    // only live edges advance the pipe
			slot[3] = slot[2];
			slot[2] = slot[1];
			slot[1] = slot[0];
			slot[0] = item;
		end
		@(negedge Clk_32UI);
		compare_outputs();
	endtask

	task automatic drain();
		repeat (4) step(-1, 1'b0);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_values();
		compare_outputs();                                  // values left by reset itself
		repeat (3) step(-1, 1'b0);                          // flags low and status BUBBLE
	endtask

	task automatic extend_changed();
		primary_i = '1;                                     // primary above the temps
		add_item(F_RUN, 8'h01, 7'd5, 7'd20, 7'd5, 64'd50, 64'd30);
		step(n_items - 1, 1'b0);
		drain();
		primary_i = '0;                                     // primary below the temps
		add_item(F_RUN, 8'h42, 7'd9, 7'd33, 7'd8, 64'd90, 64'd8);
		step(n_items - 1, 1'b0);
		drain();
	endtask

	task automatic interval_cases();
		primary_i = rand64();
		add_item(F_RUN, 8'h03, 7'd11, 7'd40, 7'd4, 64'd12, 64'd12);  // unchanged interval
		step(n_items - 1, 1'b0);
		add_item(F_RUN, 8'h00, 7'd2, 7'd60, 7'd10, 64'd40, 64'd3);   // falls below min_intv
		step(n_items - 1, 1'b0);
		drain();
	endtask

	task automatic read_end_return();
		add_item(F_RUN, 8'h02, 7'd7, 7'd101, 7'd3, 64'd20, 64'd9);   // exactly read length
		step(n_items - 1, 1'b0);
		add_item(F_RUN, 8'h01, 7'd8, 7'd115, 7'd3, 64'd20, 64'd9);   // past read length
		step(n_items - 1, 1'b0);
		add_item(F_BREAK, 8'h03, 7'd127, 7'd44, 7'd3, 64'd5, 64'd1);
		step(n_items - 1, 1'b0);
		drain();
	endtask

	task automatic init_request();
		add_item(F_INIT, 8'h00, 7'd0, 7'd0, 7'd1, 64'd77, 64'd70);
		step(n_items - 1, 1'b0);
		drain();
	endtask

	task automatic random_stream();
		ext_status_e st;
		query_t      q;
		pos_t        fwd;
		bwt_idx_t    x2;
		bwt_idx_t    t2;
		logic        hold;
		int          base;
		int          j;
		int          k;
		primary_i = rand64();
		base      = n_items;
		for (k = 0; k < N_RAND; k++) begin
			case ($urandom_range(0, 4))
				0:       st = F_INIT;
				1, 2:    st = F_RUN;
				3:       st = F_BREAK;
				default: st = BUBBLE;
			endcase
			q      = query_t'($urandom_range(0, 255));
			q[1:0] = 2'(k);                                 // walk all four bases
			fwd    = pos_t'($urandom_range(0, 110));
			if ($urandom_range(0, 7) == 0)
				fwd = 7'd101;
			x2 = bwt_idx_t'($urandom_range(0, 30));
			t2 = bwt_idx_t'($urandom_range(0, 30));
			if ($urandom_range(0, 3) == 0)
				t2 = x2;
			add_item(st, q, pos_t'($urandom_range(0, 127)), fwd,
				pos_t'($urandom_range(1, 20)), x2, t2);
		end
		k = 0;
		j = 0;
		while (k < N_RAND) begin
			hold = (j >= 20 && j < 23) || ($urandom_range(0, 9) == 0); // pulse plus sparse stalls
			step(base + k, hold);
			if (!hold)
				k++;
			j++;
		end
		drain();
	endtask

	initial begin
		void'($urandom(72));                                // single seed for the run
		stall_i      = 1'b0;
		primary_i    = '0;
		status_i     = BUBBLE;
		query_i      = '0;
		ptr_curr_i   = '0;
		read_num_i   = '0;
		ik_x0_i      = '0;
		ik_x1_i      = '0;
		ik_x2_i      = '0;
		ik_info_i    = '0;
		forward_i_i  = '0;
		min_intv_i   = '0;
		backward_x_i = '0;
		cand_x0_i    = '0;
		cand_x1_i    = '0;
		cand_x2_i    = '0;
		wait (reset_BWT_extend == 1'b1);                    // released on a falling edge
		reset_values();
		extend_changed();
		interval_cases();
		read_end_return();
		init_request();
		random_stream();
		if (n_checks > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("no checks were executed");
			$display("TB FAILED");
			$fatal(1, "empty run");
		end
	end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;                                     // active low, held from time 0
		repeat (16) @(posedge clk_o);                       // 16 reset cycles
		@(negedge clk_o);
		rst_n_o = 1'b1;                                     // release away from the active edge
	end

	always #10 clk_o = ~clk_o;                              // 20 ns period

endmodule
